// File: files.f
+incdir+include
rtl/scpad_pkg.sv
rtl/scpad_head.sv
rtl/scpad_bank.sv
rtl/scpad_tail.sv
rtl/scpad_top.sv
tests/tb_scpad.sv

// File: rtl/scpad_bank.sv
`timescale 1ns/1ps

module scpad_bank (
    input  logic               clk,
    input  logic               n_rst,
    input  scpad_pkg::rd_req_t rd_req,
    input  scpad_pkg::wr_req_t wr_req,
    output scpad_pkg::rd_res_t rd_res,
    output scpad_pkg::wr_res_t wr_res
);
    import scpad_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic              rd_valid_q;
    logic [DATA_W-1:0] rd_data_q;
    src_e              rd_src_q;
    logic              wr_valid_q;
    src_e              wr_src_q;

    // ##############################
    // Storage array
    // ##############################

    always_ff @(posedge clk) begin
        if (wr_req.valid) begin
            mem[wr_req.addr] <= wr_req.data;
        end
    end

    // ##############################
    // Execute stage results
    // ##############################

    always_ff @(posedge clk) begin
        if (rd_req.valid) begin
            rd_data_q <= mem[rd_req.addr];  // Sees the old word when the write hits the same address
            rd_src_q  <= rd_req.src;
        end
        if (wr_req.valid) begin
            wr_src_q <= wr_req.src;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_req.valid;
            wr_valid_q <= wr_req.valid;
        end
    end

    assign rd_res = '{valid: rd_valid_q, data: rd_data_q, src: rd_src_q};
    assign wr_res = '{valid: wr_valid_q, src: wr_src_q};

    // A result appears one cycle after its request and keeps its requester
    a_rd_follows_req: assert property (@(posedge clk) disable iff (!n_rst)
        (rd_res.valid == $past(rd_req.valid))
        && (!rd_res.valid || (rd_res.src == $past(rd_req.src))))
        else $error("Read result does not follow its request");

    a_wr_follows_req: assert property (@(posedge clk) disable iff (!n_rst)
        (wr_res.valid == $past(wr_req.valid))
        && (!wr_res.valid || (wr_res.src == $past(wr_req.src))))
        else $error("Write ack does not follow its request");

endmodule

// File: rtl/scpad_head.sv
`timescale 1ns/1ps

module scpad_head (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               be_rd_valid,
    input  logic               fe_rd_valid,
    input  logic               be_wr_valid,
    input  logic               fe_wr_valid,
    input  scpad_pkg::rd_cmd_t be_rd_cmd,
    input  scpad_pkg::rd_cmd_t fe_rd_cmd,
    input  scpad_pkg::wr_cmd_t be_wr_cmd,
    input  scpad_pkg::wr_cmd_t fe_wr_cmd,
    input  logic               r_stall,
    input  logic               w_stall,
    output logic               be_stall,
    output logic               fe_stall,
    output scpad_pkg::rd_req_t rd_req,
    output scpad_pkg::wr_req_t wr_req
);
    import scpad_pkg::*;

    logic              downstream_stall;
    logic              rd_busy;
    logic              wr_busy;
    logic              be_rd_grant;
    logic              fe_rd_grant;
    logic              be_wr_grant;
    logic              fe_wr_grant;
    rd_req_t           rd_req_d;
    wr_req_t           wr_req_d;
    logic              rd_valid_q;
    logic [ADDR_W-1:0] rd_addr_q;
    src_e              rd_src_q;
    logic              wr_valid_q;
    logic [ADDR_W-1:0] wr_addr_q;
    logic [DATA_W-1:0] wr_data_q;
    src_e              wr_src_q;

    // ##############################
    // Stalls and grants
    // ##############################

    assign downstream_stall = r_stall || w_stall;
    assign rd_busy          = rd_valid_q;  // A channel is busy while its request sits here
    assign wr_busy          = wr_valid_q;

    assign be_stall = downstream_stall || (be_rd_valid && rd_busy) || (be_wr_valid && wr_busy);
    assign fe_stall = downstream_stall
                   || (fe_rd_valid && (rd_busy || be_rd_valid))
                   || (fe_wr_valid && (wr_busy || be_wr_valid));

    // One stall covers both channels of a requester
    assign be_rd_grant = be_rd_valid && !be_stall;
    assign fe_rd_grant = fe_rd_valid && !fe_stall;
    assign be_wr_grant = be_wr_valid && !be_stall;
    assign fe_wr_grant = fe_wr_valid && !fe_stall;

    always_comb begin
        rd_req_d = '0;
        if (be_rd_grant) begin
            rd_req_d = '{valid: 1'b1, addr: be_rd_cmd.addr, src: SRC_BE};
        end else if (fe_rd_grant) begin
            rd_req_d = '{valid: 1'b1, addr: fe_rd_cmd.addr, src: SRC_FE};
        end
    end

    always_comb begin
        wr_req_d = '0;
        if (be_wr_grant) begin
            wr_req_d = '{valid: 1'b1, addr: be_wr_cmd.addr, data: be_wr_cmd.data, src: SRC_BE};
        end else if (fe_wr_grant) begin
            wr_req_d = '{valid: 1'b1, addr: fe_wr_cmd.addr, data: fe_wr_cmd.data, src: SRC_FE};
        end
    end

    // ##############################
    // Decode stage registers
    // ##############################

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_req_d.valid;  // High for exactly one cycle per grant
            wr_valid_q <= wr_req_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req_d.valid) begin
            rd_addr_q <= rd_req_d.addr;
            rd_src_q  <= rd_req_d.src;
        end
        if (wr_req_d.valid) begin
            wr_addr_q <= wr_req_d.addr;
            wr_data_q <= wr_req_d.data;
            wr_src_q  <= wr_req_d.src;
        end
    end

    assign rd_req = '{valid: rd_valid_q, addr: rd_addr_q, src: rd_src_q};
    assign wr_req = '{valid: wr_valid_q, addr: wr_addr_q, data: wr_data_q, src: wr_src_q};

    a_rd_single_grant: assert property (@(posedge clk) disable iff (!n_rst)
        !(be_rd_grant && fe_rd_grant))
        else $error("Read channel granted to both requesters");

    a_wr_single_grant: assert property (@(posedge clk) disable iff (!n_rst)
        !(be_wr_grant && fe_wr_grant))
        else $error("Write channel granted to both requesters");

endmodule

// File: rtl/scpad_pkg.sv
package scpad_pkg;

    // ##############################
    // Widths and depths
    // ##############################

    localparam int ADDR_W          = 6;
    localparam int DATA_W          = 32;
    localparam int MEM_DEPTH       = 64;
    localparam int RESP_FIFO_DEPTH = 4;
    localparam int STALL_LEVEL     = 2;  // Leaves room for the two requests still in flight
    localparam int PTR_W           = $clog2(RESP_FIFO_DEPTH);
    localparam int CNT_W           = $clog2(RESP_FIFO_DEPTH + 1);

    // ##############################
    // Requester identity
    // ##############################

    typedef enum logic {
        SRC_BE = 1'b0,  // Back end, the high priority side
        SRC_FE = 1'b1
    } src_e;

    // ##############################
    // Commands, requests and results
    // ##############################

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } rd_cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } wr_cmd_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        src_e              src;
    } rd_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        src_e              src;
    } wr_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        src_e              src;
    } rd_res_t;

    typedef struct packed {
        logic valid;
        src_e src;  // Requester that gets the ack
    } wr_res_t;

endpackage

// File: rtl/scpad_tail.sv
`timescale 1ns/1ps

module scpad_tail (
    input  logic                         clk,
    input  logic                         n_rst,
    input  scpad_pkg::rd_res_t           rd_res,
    input  scpad_pkg::wr_res_t           wr_res,
    input  logic                         be_rd_ready,
    input  logic                         fe_rd_ready,
    input  logic                         be_ack_ready,
    input  logic                         fe_ack_ready,
    output logic                         be_rd_rvalid,
    output logic                         fe_rd_rvalid,
    output logic                         be_wr_ack,
    output logic                         fe_wr_ack,
    output logic [scpad_pkg::DATA_W-1:0] be_rd_data,
    output logic [scpad_pkg::DATA_W-1:0] fe_rd_data,
    output logic                         r_stall,
    output logic                         w_stall
);
    import scpad_pkg::*;

    typedef struct packed {
        src_e              src;
        logic [DATA_W-1:0] data;
    } entry_t;

    // Index 0 is the read data FIFO, index 1 the write ack FIFO
    entry_t     in_ent   [2];
    entry_t     head_ent [2];
    logic [1:0] push;
    logic [1:0] pop;
    logic [1:0] full;
    logic [1:0] not_empty;
    logic [1:0] be_rdy;
    logic [1:0] fe_rdy;
    logic [1:0] be_vld;
    logic [1:0] fe_vld;
    logic [1:0] stall;

    assign push[0]   = rd_res.valid;
    assign push[1]   = wr_res.valid;
    assign in_ent[0] = '{src: rd_res.src, data: rd_res.data};
    assign in_ent[1] = '{src: wr_res.src, data: '0};  // Acks carry no data
    assign be_rdy    = {be_ack_ready, be_rd_ready};
    assign fe_rdy    = {fe_ack_ready, fe_rd_ready};

    // ##############################
    // Response FIFOs
    // ##############################

    for (genvar c = 0; c < 2; c++) begin : g_fifo
        entry_t           ent [RESP_FIFO_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;

        always_ff @(posedge clk, negedge n_rst) begin
            if (!n_rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push[c]) begin
                    wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two so pointers wrap
                end
                if (pop[c]) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                case ({push[c], pop[c]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (push[c]) begin
                ent[wr_ptr] <= in_ent[c];
            end
        end

        assign head_ent[c]  = ent[rd_ptr];
        assign not_empty[c] = (count != '0);
        assign full[c]      = (count == CNT_W'(RESP_FIFO_DEPTH));
        assign stall[c]     = (count >= CNT_W'(STALL_LEVEL));

        // The head entry only shows to its own requester and may block the other one
        assign be_vld[c] = not_empty[c] && (head_ent[c].src == SRC_BE);
        assign fe_vld[c] = not_empty[c] && (head_ent[c].src == SRC_FE);
        assign pop[c]    = (be_vld[c] && be_rdy[c]) || (fe_vld[c] && fe_rdy[c]);

        // Holds only if head stalls early enough for everything in flight
        a_no_push_full: assert property (@(posedge clk) disable iff (!n_rst)
            !(push[c] && full[c]))
            else $error("Response FIFO %0d pushed while full", c);
    end

    // ##############################
    // Requester outputs
    // ##############################

    assign be_rd_rvalid = be_vld[0];
    assign fe_rd_rvalid = fe_vld[0];
    assign be_rd_data   = head_ent[0].data;
    assign fe_rd_data   = head_ent[0].data;
    assign be_wr_ack    = be_vld[1];
    assign fe_wr_ack    = fe_vld[1];
    assign r_stall      = stall[0];
    assign w_stall      = stall[1];

endmodule

// File: rtl/scpad_top.sv
`timescale 1ns/1ps

module scpad_top (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         be_rd_valid,
    input  logic                         fe_rd_valid,
    input  logic                         be_wr_valid,
    input  logic                         fe_wr_valid,
    input  scpad_pkg::rd_cmd_t           be_rd_cmd,
    input  scpad_pkg::rd_cmd_t           fe_rd_cmd,
    input  scpad_pkg::wr_cmd_t           be_wr_cmd,
    input  scpad_pkg::wr_cmd_t           fe_wr_cmd,
    output logic                         be_stall,
    output logic                         fe_stall,
    input  logic                         be_rd_ready,
    input  logic                         fe_rd_ready,
    input  logic                         be_ack_ready,
    input  logic                         fe_ack_ready,
    output logic                         be_rd_rvalid,
    output logic                         fe_rd_rvalid,
    output logic                         be_wr_ack,
    output logic                         fe_wr_ack,
    output logic [scpad_pkg::DATA_W-1:0] be_rd_data,
    output logic [scpad_pkg::DATA_W-1:0] fe_rd_data
);
    import scpad_pkg::*;

    rd_req_t rd_req;  // Decode to execute
    wr_req_t wr_req;
    rd_res_t rd_res;  // Execute to result
    wr_res_t wr_res;
    logic    r_stall;
    logic    w_stall;

    scpad_head i_head (
        .clk         (clk),
        .n_rst       (n_rst),
        .be_rd_valid (be_rd_valid),
        .fe_rd_valid (fe_rd_valid),
        .be_wr_valid (be_wr_valid),
        .fe_wr_valid (fe_wr_valid),
        .be_rd_cmd   (be_rd_cmd),
        .fe_rd_cmd   (fe_rd_cmd),
        .be_wr_cmd   (be_wr_cmd),
        .fe_wr_cmd   (fe_wr_cmd),
        .r_stall     (r_stall),
        .w_stall     (w_stall),
        .be_stall    (be_stall),
        .fe_stall    (fe_stall),
        .rd_req      (rd_req),
        .wr_req      (wr_req)
    );

    scpad_bank i_bank (
        .clk    (clk),
        .n_rst  (n_rst),
        .rd_req (rd_req),
        .wr_req (wr_req),
        .rd_res (rd_res),
        .wr_res (wr_res)
    );

    scpad_tail i_tail (
        .clk          (clk),
        .n_rst        (n_rst),
        .rd_res       (rd_res),
        .wr_res       (wr_res),
        .be_rd_ready  (be_rd_ready),
        .fe_rd_ready  (fe_rd_ready),
        .be_ack_ready (be_ack_ready),
        .fe_ack_ready (fe_ack_ready),
        .be_rd_rvalid (be_rd_rvalid),
        .fe_rd_rvalid (fe_rd_rvalid),
        .be_wr_ack    (be_wr_ack),
        .fe_wr_ack    (fe_wr_ack),
        .be_rd_data   (be_rd_data),
        .fe_rd_data   (fe_rd_data),
        .r_stall      (r_stall),
        .w_stall      (w_stall)
    );

endmodule

// File: run.sh
#!/bin/sh
# Builds the scratchpad testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_scpad \
    -Mdir "$BUILD_DIR" \
    -o tb_scpad_sim \
    -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_scpad_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// File: include/tb_scpad_ref.svh
`ifndef TB_SCPAD_REF_SVH
`define TB_SCPAD_REF_SVH

// ##############################
// Random source
// ##############################

logic [31:0] lfsr_state = 32'd99300;

function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;  // Taps 32, 22, 2, 1
    end
    return out_bit;
endfunction

function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[30:0], lfsr_step()};  // One step per bit taken
    end
    return val;
endfunction

// ##############################
// Reference model
// ##############################

typedef struct packed {
    logic                         known;  // Clear when the word was never written
    logic [scpad_pkg::DATA_W-1:0] data;
} exp_rd_t;

logic [scpad_pkg::DATA_W-1:0] ref_mem      [scpad_pkg::MEM_DEPTH];
logic                         ref_written  [scpad_pkg::MEM_DEPTH];
exp_rd_t                      exp_be_rd_q  [$];
exp_rd_t                      exp_fe_rd_q  [$];
logic [scpad_pkg::ADDR_W-1:0] exp_be_ack_q [$];
logic [scpad_pkg::ADDR_W-1:0] exp_fe_ack_q [$];

function automatic void ref_clear();
    foreach (ref_written[i]) begin
        ref_written[i] = 1'b0;
    end
    exp_be_rd_q.delete();
    exp_fe_rd_q.delete();
    exp_be_ack_q.delete();
    exp_fe_ack_q.delete();
endfunction

// Apply the read of an edge before its write so the read sees the old word
function automatic void ref_read(input scpad_pkg::src_e src,
                                 input logic [scpad_pkg::ADDR_W-1:0] addr);
    exp_rd_t ent;
    ent.known = ref_written[addr];
    ent.data  = ref_mem[addr];
    if (src == scpad_pkg::SRC_BE) begin
        exp_be_rd_q.push_back(ent);
    end else begin
        exp_fe_rd_q.push_back(ent);
    end
endfunction

function automatic void ref_write(input scpad_pkg::src_e src,
                                  input logic [scpad_pkg::ADDR_W-1:0] addr,
                                  input logic [scpad_pkg::DATA_W-1:0] data);
    ref_mem[addr]     = data;
    ref_written[addr] = 1'b1;
    if (src == scpad_pkg::SRC_BE) begin
        exp_be_ack_q.push_back(addr);
    end else begin
        exp_fe_ack_q.push_back(addr);
    end
endfunction

function automatic int ref_pending();
    return exp_be_rd_q.size() + exp_fe_rd_q.size() + exp_be_ack_q.size() + exp_fe_ack_q.size();
endfunction

`endif

// File: tests/tb_scpad.sv
`timescale 1ns/1ps

module tb_scpad;
    import scpad_pkg::*;

    `include "tb_scpad_ref.svh"

    logic              clk;
    logic              n_rst;
    logic [3:0]        req_valid;  // Channels 0 be_rd, 1 fe_rd, 2 be_wr, 3 fe_wr
    logic [3:0]        rdy;        // Same order with the ack readies in 2 and 3
    logic [3:0]        accepted;
    rd_cmd_t           be_rd_cmd;
    rd_cmd_t           fe_rd_cmd;
    wr_cmd_t           be_wr_cmd;
    wr_cmd_t           fe_wr_cmd;
    logic              be_stall;
    logic              fe_stall;
    logic              be_rd_rvalid;
    logic              fe_rd_rvalid;
    logic              be_wr_ack;
    logic              fe_wr_ack;
    logic [DATA_W-1:0] be_rd_data;
    logic [DATA_W-1:0] fe_rd_data;

    scpad_top i_scpad_top (
        .clk          (clk),
        .n_rst        (n_rst),
        .be_rd_valid  (req_valid[0]),
        .fe_rd_valid  (req_valid[1]),
        .be_wr_valid  (req_valid[2]),
        .fe_wr_valid  (req_valid[3]),
        .be_rd_cmd    (be_rd_cmd),
        .fe_rd_cmd    (fe_rd_cmd),
        .be_wr_cmd    (be_wr_cmd),
        .fe_wr_cmd    (fe_wr_cmd),
        .be_stall     (be_stall),
        .fe_stall     (fe_stall),
        .be_rd_ready  (rdy[0]),
        .fe_rd_ready  (rdy[1]),
        .be_ack_ready (rdy[2]),
        .fe_ack_ready (rdy[3]),
        .be_rd_rvalid (be_rd_rvalid),
        .fe_rd_rvalid (fe_rd_rvalid),
        .be_wr_ack    (be_wr_ack),
        .fe_wr_ack    (fe_wr_ack),
        .be_rd_data   (be_rd_data),
        .fe_rd_data   (fe_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ##############################
    // Failure and check helpers
    // ##############################

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, want, got);
            stop_with_failure();
        end
    endtask

    task automatic check_read_resp(input src_e src, input logic [DATA_W-1:0] got);
        exp_rd_t exp;
        int      left;
        string   name;
        name = (src == SRC_BE) ? "be_rd_data" : "fe_rd_data";
        left = (src == SRC_BE) ? exp_be_rd_q.size() : exp_fe_rd_q.size();
        assert (left > 0) else begin
            $display("Read data came back on %s with no read outstanding", name);
            stop_with_failure();
        end
        if (src == SRC_BE) begin
            exp = exp_be_rd_q.pop_front();
        end else begin
            exp = exp_fe_rd_q.pop_front();
        end
        assert (!exp.known || got === exp.data) else begin
            $display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, exp.data, got);
            stop_with_failure();
        end
    endtask

    task automatic check_ack_resp(input src_e src);
        int left;
        left = (src == SRC_BE) ? exp_be_ack_q.size() : exp_fe_ack_q.size();
        assert (left > 0) else begin
            $display("A write ack came back with no write outstanding for that requester");
            stop_with_failure();
        end
        if (src == SRC_BE) begin
            void'(exp_be_ack_q.pop_front());
        end else begin
            void'(exp_fe_ack_q.pop_front());
        end
    endtask

    // ##############################
    // Comparing process
    // ##############################

    always @(posedge clk) begin : monitor
        logic [3:0] acc;
        if (n_rst) begin
            acc = req_valid & ~{fe_stall, be_stall, fe_stall, be_stall};
            if (be_rd_rvalid && rdy[0]) begin
                check_read_resp(SRC_BE, be_rd_data);
            end
            if (fe_rd_rvalid && rdy[1]) begin
                check_read_resp(SRC_FE, fe_rd_data);
            end
            if (be_wr_ack && rdy[2]) begin
                check_ack_resp(SRC_BE);
            end
            if (fe_wr_ack && rdy[3]) begin
                check_ack_resp(SRC_FE);
            end
            if ((req_valid[0] && req_valid[1]) || (req_valid[2] && req_valid[3])) begin
                check_bit("fe_stall", fe_stall, 1'b1);  // be wins a shared channel
            end
            if (acc[0]) begin
                ref_read(SRC_BE, be_rd_cmd.addr);
            end
            if (acc[1]) begin
                ref_read(SRC_FE, fe_rd_cmd.addr);
            end
            if (acc[2]) begin
                ref_write(SRC_BE, be_wr_cmd.addr, be_wr_cmd.data);
            end
            if (acc[3]) begin
                ref_write(SRC_FE, fe_wr_cmd.addr, fe_wr_cmd.data);
            end
            accepted = accepted | acc;
        end
    end

    // ##############################
    // Stimulus helpers
    // ##############################

    task automatic set_request(input int ch, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
        case (ch)
            0:       be_rd_cmd.addr = addr;
            1:       fe_rd_cmd.addr = addr;
            2:       be_wr_cmd = '{addr: addr, data: data};
            default: fe_wr_cmd = '{addr: addr, data: data};
        endcase
        req_valid[ch] = 1'b1;
    endtask

    task automatic release_accepted();
        for (int ch = 0; ch < 4; ch++) begin
            if (accepted[ch]) begin
                req_valid[ch] = 1'b0;
                accepted[ch]  = 1'b0;
            end
        end
    endtask

    task automatic wait_accepted();
        int waited;
        waited = 0;
        while (req_valid != 4'b0) begin
            @(negedge clk);
            release_accepted();
            waited++;
            if (waited > 200) begin
                $display("Timeout while a request waited to be accepted");
                stop_with_failure();
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        wait_accepted();
        waited = 0;
        while (ref_pending() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 200) begin
                $display("Timeout while %0d responses were still outstanding", ref_pending());
                stop_with_failure();
            end
        end
    endtask

    task automatic random_cycle(input logic ready_low);
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        @(negedge clk);
        release_accepted();
        for (int ch = 0; ch < 4; ch++) begin
            if (!req_valid[ch] && lfsr_step()) begin
                addr = ADDR_W'(lfsr_bits(3));  // Few addresses so reads often meet writes
                data = lfsr_bits(32);
                set_request(ch, addr, data);
            end
            rdy[ch] = ready_low ? 1'b0 : (lfsr_bits(2) != 32'd0);
        end
    endtask

    // ##############################
    // Test sequence
    // ##############################

    initial begin
        n_rst     = 1'b0;
        req_valid = '0;
        rdy       = 4'hf;
        accepted  = '0;
        be_rd_cmd = '0;
        fe_rd_cmd = '0;
        be_wr_cmd = '0;
        fe_wr_cmd = '0;
        ref_clear();
        repeat (2) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        check_bit("be_rd_rvalid", be_rd_rvalid, 1'b0);
        check_bit("fe_rd_rvalid", fe_rd_rvalid, 1'b0);
        check_bit("be_wr_ack", be_wr_ack, 1'b0);
        check_bit("fe_wr_ack", fe_wr_ack, 1'b0);
        check_bit("be_stall", be_stall, 1'b0);
        check_bit("fe_stall", fe_stall, 1'b0);

        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 8; i++) begin
                set_request(2 + s, ADDR_W'(s * 8 + i), lfsr_bits(32));
                wait_accepted();
            end
            for (int i = 0; i < 8; i++) begin
                set_request(s, ADDR_W'(s * 8 + i), '0);
                wait_accepted();
            end
            wait_drained();
        end

        // Both requesters on one channel, be has to go first
        for (int c = 0; c < 4; c += 2) begin
            set_request(c, ADDR_W'(1), lfsr_bits(32));
            set_request(c + 1, ADDR_W'(9), lfsr_bits(32));
            @(negedge clk);
            check_bit("be accepted", accepted[c], 1'b1);
            check_bit("fe accepted", accepted[c + 1], 1'b0);
            release_accepted();
            wait_drained();
        end

        set_request(0, ADDR_W'(3), '0);
        set_request(3, ADDR_W'(3), lfsr_bits(32));
        @(negedge clk);
        check_bit("be_rd accepted", accepted[0], 1'b1);
        check_bit("fe_wr accepted", accepted[3], 1'b1);
        release_accepted();
        set_request(1, ADDR_W'(3), '0);  // Sees the word written above
        wait_drained();

        for (int i = 0; i < 24; i++) begin
            random_cycle(1'b1);
        end
        check_bit("be_stall", be_stall, 1'b1);
        check_bit("fe_stall", fe_stall, 1'b1);
        rdy = 4'hf;
        wait_drained();

        for (int i = 0; i < 2000; i++) begin
            random_cycle(1'b0);
        end
        rdy = 4'hf;
        wait_drained();

        if (ref_pending() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Expected responses were left over at the end of the run");
            stop_with_failure();
        end
    end

endmodule
